// ==== compile.f ====
+incdir+include
src/core_pkg.sv
src/reset_seq.sv
src/loader_bridge.sv
src/ce_gen.sv
src/audio_mix.sv
src/synth_display.sv
src/core_glue_top.sv
dv/core_glue_sva.sv
dv/tb_core_glue.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core glue testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wall -Wno-fatal \
	-f compile.f --top-module tb_core_glue -o Vtb_core_glue

# The simulator may stop early on an assertion, so the log decides
./obj_dir/Vtb_core_glue > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
	exit 1
fi
exit 0

// ==== dv/tb_core_glue.sv ====
// Testbench that drives the core glue top through each block's rules and reports per test
`default_nettype none
`timescale 1ns/1ps

`include "core_glue_params.svh"

module tb_core_glue;
	import core_pkg::*;

	// Cycle budget of all tests plus slack
	localparam int TEST_CYCLES = 1300;
	localparam int MARGIN      = 500;

	logic clk_sys = 1'b0;
	logic rst_n, user_btn, download, ioctl_wr, ldr_ack;
	logic synth_avail, synth_newmode, lcd_en, lcd_pix, lcd_update;
	status_t status;
	ldr_addr_t ioctl_addr;
	ldr_data_t ioctl_dout;
	stereo_t core_audio, synth_audio, audio_out;
	logic [7:0] synth_mode, synth_rom, synth_sf;
	rgb_t video_in, video_out;
	logic core_rst_n, ioctl_wait, ldr_wr, ldr_aen, ldr_done, info_req, synth_mute;
	ldr_addr_t ldr_addr;
	ldr_data_t ldr_data;
	ce_t ce;
	info_code_t info_code;
	integer seed = 32'he232;
	int errors = 0;
	int tests = 0;
	int test_err = 0;

	always #2 clk_sys = ~clk_sys;

	core_glue_top #(.lcd_hold(20)) u_dut (.*);

	bind core_glue_top core_glue_sva u_sva (.*);

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			errors++;
			test_err++;
			$display("Mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s finished with %0d errors", name, test_err);
		test_err = 0;
	endtask

	task automatic apply_reset;
		rst_n = 1'b0;
		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;
	endtask

	task automatic tick(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// Reference model of the mixer and compressor
	function automatic logic [15:0] model_audio(input int s, input logic en, input logic cur);
		int m, r;
		logic [15:0] w;
		w = 16'(s);
		if (!en)
			return w;
		m = w[15] ? 65536 - int'(w) : int'(w);
		if (!cur)
			r = (m < `CMP1_KNEE) ? m * `CMP1_GAIN : (m - `CMP1_KNEE) / `CMP1_FALL + `CMP1_BASE;
		else
			r = (m < `CMP2_KNEE) ? m * `CMP2_GAIN : (m - `CMP2_KNEE) / `CMP2_FALL + `CMP2_BASE;
		r = r & 32'hffff;
		return w[15] ? 16'(-r) : 16'(r);
	endfunction

	function automatic chan_t model_blend(input chan_t ch, input logic pix);
		return (pix ? 8'hc0 : 8'h00) | (ch >> 2);
	endfunction

	task automatic audio_step(input string name, input int c, input int s);
		sample_t exp;
		logic    mute;
		mute = synth_avail & status[`ST_SYNTH_DIS];
		core_audio  = '{left: 16'(c), right: 16'(-c)};
		synth_audio = '{left: 16'(s), right: 16'(s)};
		exp = model_audio(mute ? c : c + s, status[`ST_CMP_EN], status[`ST_CMP_CURVE]);
		tick(2);
		check_eq({name, ".left"}, exp, audio_out.left);
		exp = model_audio(mute ? -c : -c + s, status[`ST_CMP_EN], status[`ST_CMP_CURVE]);
		check_eq({name, ".right"}, exp, audio_out.right);
	endtask

	// Watchdog sized from the test budget
	initial begin
		#((TEST_CYCLES + MARGIN) * 4);
		$display("Watchdog expired, the run did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int edges[8] = '{32767, -32767, 14044, 14043, 7400, 7399, 0, -14044};
		int cnt;
		rst_n = 1'b0;
		user_btn = 1'b0;
		download = 1'b0;
		ioctl_wr = 1'b0;
		ldr_ack = 1'b0;
		status = '0;
		status[`ST_RESET] = 1'b1;
		ioctl_addr = '0;
		ioctl_dout = '0;
		core_audio = '0;
		synth_audio = '0;
		synth_avail = 1'b0;
		synth_newmode = 1'b0;
		synth_mode = '0;
		synth_rom = '0;
		synth_sf = '0;
		lcd_en = 1'b0;
		lcd_pix = 1'b0;
		lcd_update = 1'b0;
		video_in = '0;

		// Enable cadence in both sound modes under the bound assertions
		@(negedge clk_sys);
		apply_reset();
		tick(80);
		rst_n = 1'b0;
		status[`ST_SND_MODE] = 1'b1;
		apply_reset();
		tick(80);
		end_test("ce_cadence");

		// Loader with a late ack
		download = 1'b1;
		ioctl_wr = 1'b1;
		ioctl_addr = 20'h12345;
		ioctl_dout = 8'h5a;
		tick(1);
		ioctl_wr = 1'b0;
		repeat (5) begin
			tick(1);
			check_eq("ldr_wr_held", 1, ldr_wr);
			check_eq("ioctl_wait_held", 1, ioctl_wait);
		end
		check_eq("ldr_addr", 20'h12345, ldr_addr);
		check_eq("ldr_data", 8'h5a, ldr_data);
		check_eq("ldr_aen", 1, ldr_aen);
		ldr_ack = 1'b1;
		tick(1);
		check_eq("ldr_wr_release", 0, ldr_wr);
		ldr_ack = 1'b0;
		download = 1'b0;
		cnt = 0;
		while (!ldr_done && cnt < 10) begin
			tick(1);
			cnt++;
		end
		if (!ldr_done) begin
			errors++;
			test_err++;
			$display("ldr_done never set after download fell");
		end
		download = 1'b1;
		ioctl_wr = 1'b1;
		tick(1);
		ioctl_wr = 1'b0;
		check_eq("ldr_aen_done", 0, ldr_aen);
		download = 1'b0;
		tick(1);
		check_eq("late_write_ignored", 0, ldr_wr);
		check_eq("core_rst_held", 0, core_rst_n);
		end_test("loader");

		// Release after download and a host reset fall and drop on the button
		status[`ST_RESET] = 1'b0;
		tick(1);
		check_eq("core_rst_release", 1, core_rst_n);
		user_btn = 1'b1;
		tick(1);
		check_eq("core_rst_button", 0, core_rst_n);
		user_btn = 1'b0;
		tick(1);
		// Fresh start where the reset bit falls before any download
		status[`ST_RESET] = 1'b1;
		apply_reset();
		tick(1);
		status[`ST_RESET] = 1'b0;
		tick(2);
		check_eq("core_rst_no_download", 0, core_rst_n);
		download = 1'b1;
		tick(1);
		check_eq("core_rst_download", 1, core_rst_n);
		download = 1'b0;
		// Fresh start with the reset bit low from the beginning never sees a fall
		apply_reset();
		download = 1'b1;
		tick(2);
		check_eq("core_rst_no_fall", 0, core_rst_n);
		download = 1'b0;
		tick(1);
		end_test("reset_seq");

		// Audio over curves, compression and mute
		synth_avail = 1'b1;
		for (int k = 0; k < 8; k++) begin
			status[`ST_CMP_EN] = k[0];
			status[`ST_CMP_CURVE] = k[1];
			status[`ST_SYNTH_DIS] = k[2];
			tick(1);
			check_eq($sformatf("synth_mute_%0d", k), k[2], synth_mute);
			foreach (edges[i])
				audio_step($sformatf("audio_edge_%0d_%0d", k, i), edges[i], 0);
			for (int i = 0; i < 16; i++)
				audio_step($sformatf("audio_rand_%0d_%0d", k, i), $random(seed), $random(seed));
		end
		synth_avail = 1'b0;
		tick(1);
		check_eq("synth_mute_unavail", 0, synth_mute);
		end_test("audio");

		// Display info code, request and overlay
		synth_mode = `SYNTH_MODE_FONT;
		synth_sf = 8'd5;
		tick(1);
		check_eq("info_code_font", 6, info_code);
		synth_mode = `SYNTH_MODE_ROM;
		for (int r = 0; r < 4; r++) begin
			synth_rom = 8'(r);
			tick(1);
			check_eq($sformatf("info_code_rom%0d", r), (r < 3) ? 9 + r : 12, info_code);
		end
		synth_mode = 8'h00;
		tick(1);
		check_eq("info_code_other", 12, info_code);
		status[`ST_INFO_LO +: 2] = info_off;
		synth_newmode = ~synth_newmode;
		tick(1);
		check_eq("info_req_off", 0, info_req);
		status[`ST_INFO_LO +: 2] = info_menu;
		tick(1);
		synth_newmode = ~synth_newmode;
		tick(1);
		check_eq("info_req_pulse", 1, info_req);
		tick(1);
		check_eq("info_req_end", 0, info_req);
		lcd_en = 1'b1;
		lcd_pix = 1'b1;
		video_in = '{8'h12, 8'h34, 8'h56};
		tick(1);
		check_eq("overlay_menu", 24'h123456, video_out);
		status[`ST_INFO_LO +: 2] = info_lcd_on;
		tick(1);
		check_eq("overlay_on", {model_blend(8'h12, 1'b1), model_blend(8'h34, 1'b1),
			model_blend(8'h56, 1'b1)}, video_out);
		status[`ST_INFO_LO +: 2] = info_lcd_auto;
		lcd_pix = 1'b0;
		tick(2);
		check_eq("overlay_auto_idle", 24'h123456, video_out);
		lcd_update = ~lcd_update;
		tick(1);
		cnt = 0;
		while (video_out != video_in && cnt < 40) begin
			cnt++;
			tick(1);
		end
		check_eq("overlay_auto_cycles", 20, cnt);
		end_test("display");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/core_glue_sva.sv ====
// Timing assertions bound to the core glue top DUT from the testbench
`default_nettype none
`timescale 1ns/1ps

`include "core_glue_params.svh"

module core_glue_sva
	import core_pkg::*;
(
	input logic    clk_sys,
	input logic    rst_n,
	input status_t status,
	input ce_t     ce,
	input logic    ldr_wr,
	input logic    ldr_ack,
	input logic    ioctl_wr,
	input stereo_t core_audio,
	input stereo_t synth_audio,
	input logic    synth_mute,
	input stereo_t audio_out,
	input logic    info_req
);

	default clocking cb @(posedge clk_sys);
	endclocking

	default disable iff (!rst_n);

	////////////////////////////////////////////////////////////
	// Enable periods

	a_sys_cep: assert property (ce.sys_cep |=> !ce.sys_cep [*`SYS_CE_DIV-1] ##1 ce.sys_cep)
		else $error("sys_cep period wrong");
	a_sys_cen_per: assert property (ce.sys_cen |=> !ce.sys_cen [*`SYS_CE_DIV-1] ##1 ce.sys_cen)
		else $error("sys_cen period wrong");
	// Negative phase two cycles after the positive one
	a_sys_cen: assert property (ce.sys_cep |-> ##2 ce.sys_cen)
		else $error("sys_cen phase wrong");
	a_opn0: assert property (ce.opn_ce[0] |=> !ce.opn_ce[0] [*`SND_DIV_SLOW-1] ##1 ce.opn_ce[0])
		else $error("opn_ce[0] period wrong");
	a_opn1: assert property (ce.opn_ce[1] |=> !ce.opn_ce[1] [*`OPN_DIV_SLOW-1] ##1 ce.opn_ce[1])
		else $error("opn_ce[1] period wrong");
	a_snd_slow: assert property ((ce.snd_ce && status[`ST_SND_MODE])
			|=> !ce.snd_ce [*`SND_DIV_SLOW-1] ##1 ce.snd_ce)
		else $error("snd_ce slow period wrong");
	a_snd_fast: assert property ((ce.snd_ce && !status[`ST_SND_MODE])
			|=> !ce.snd_ce [*`SND_DIV_FAST-1] ##1 ce.snd_ce)
		else $error("snd_ce fast period wrong");

	////////////////////////////////////////////////////////////
	// Loader hold and release

	a_wr_hold: assert property ((ldr_wr && !$rose(ldr_ack) && !ioctl_wr) |=> ldr_wr)
		else $error("ldr_wr dropped without ack");
	a_wr_release: assert property ((ldr_wr && $rose(ldr_ack) && !ioctl_wr) |=> !ldr_wr)
		else $error("ldr_wr held after ack");

	// Uncompressed path shows the wrapped sum two cycles later
	a_audio_lat: assert property ((!status[`ST_CMP_EN] && !synth_mute) |-> ##2
			(audio_out.left == $past(16'(core_audio.left + synth_audio.left), 2)))
		else $error("audio latency wrong");

	a_info_req: assert property (info_req |=> !info_req)
		else $error("info_req wider than one cycle");

endmodule

`default_nettype wire

// ==== src/core_glue_top.sv ====
// Top of the core glue, decodes the host status word and connects reset, loader, enables, audio and display
`default_nettype none
`timescale 1ns/1ps

`include "core_glue_params.svh"

module core_glue_top
	import core_pkg::*;
#(
	parameter int unsigned lcd_hold = `LCD_HOLD_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	// Host side
	input  status_t    status,
	input  logic       user_btn,
	input  logic       download,
	input  logic       ioctl_wr,
	input  ldr_addr_t  ioctl_addr,
	input  ldr_data_t  ioctl_dout,
	// Core and synth side
	input  logic       ldr_ack,
	input  stereo_t    core_audio,
	input  stereo_t    synth_audio,
	input  logic       synth_avail,
	input  logic       synth_newmode,
	input  logic [7:0] synth_mode,
	input  logic [7:0] synth_rom,
	input  logic [7:0] synth_sf,
	input  logic       lcd_en,
	input  logic       lcd_pix,
	input  logic       lcd_update,
	input  rgb_t       video_in,
	// Outputs
	output logic       core_rst_n,
	output logic       ioctl_wait,
	output logic       ldr_wr,
	output ldr_addr_t  ldr_addr,
	output ldr_data_t  ldr_data,
	output logic       ldr_aen,
	output logic       ldr_done,
	output ce_t        ce,
	output stereo_t    audio_out,
	output logic       info_req,
	output info_code_t info_code,
	output rgb_t       video_out,
	output logic       synth_mute
);

	info_mode_t info_mode;

	// Status fields
	assign info_mode  = info_mode_t'(status[`ST_INFO_LO +: 2]);
	assign synth_mute = synth_avail & status[`ST_SYNTH_DIS];
	// Host stalls while a write waits for the core
	assign ioctl_wait = ldr_wr;

	reset_seq u_reset_seq (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.user_btn  (user_btn),
		.host_reset(status[`ST_RESET]),
		.download  (download),
		.core_rst_n(core_rst_n)
	);

	loader_bridge u_loader_bridge (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.download  (download),
		.ioctl_wr  (ioctl_wr),
		.ldr_ack   (ldr_ack),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.ldr_wr    (ldr_wr),
		.ldr_aen   (ldr_aen),
		.ldr_done  (ldr_done),
		.ldr_addr  (ldr_addr),
		.ldr_data  (ldr_data)
	);

	ce_gen u_ce_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.snd_slow(status[`ST_SND_MODE]),
		.ce      (ce)
	);

	audio_mix u_audio_mix (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.core_audio (core_audio),
		.synth_audio(synth_audio),
		.synth_mute (synth_mute),
		.cmp_en     (status[`ST_CMP_EN]),
		.cmp_curve  (status[`ST_CMP_CURVE]),
		.audio_out  (audio_out)
	);

	synth_display #(
		.lcd_hold(lcd_hold)
	) u_synth_display (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.info_mode    (info_mode),
		.synth_newmode(synth_newmode),
		.synth_mode   (synth_mode),
		.synth_rom    (synth_rom),
		.synth_sf     (synth_sf),
		.lcd_en       (lcd_en),
		.lcd_pix      (lcd_pix),
		.lcd_update   (lcd_update),
		.video_in     (video_in),
		.info_req     (info_req),
		.info_code    (info_code),
		.video_out    (video_out)
	);

endmodule

`default_nettype wire

// ==== src/synth_display.sv ====
// Synth info display, builds the menu info code and request and overlays the synth LCD on video
`default_nettype none
`timescale 1ns/1ps

`include "core_glue_params.svh"

module synth_display
	import core_pkg::*;
#(
	parameter int unsigned lcd_hold = `LCD_HOLD_DEFAULT
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  info_mode_t info_mode,
	input  logic       synth_newmode,
	input  logic [7:0] synth_mode,
	input  logic [7:0] synth_rom,
	input  logic [7:0] synth_sf,
	input  logic       lcd_en,
	input  logic       lcd_pix,
	input  logic       lcd_update,
	input  rgb_t       video_in,
	output logic       info_req,
	output info_code_t info_code,
	output rgb_t       video_out
);

	localparam int HOLD_W = (lcd_hold > 1) ? $clog2(lcd_hold) : 1;

	logic              old_newmode;
	logic              old_update;
	logic              lcd_on;
	logic              overlay;
	logic [HOLD_W-1:0] hold_cnt;

	function automatic chan_t blend(input chan_t ch, input logic pix);
		return {{2{pix}}, ch[7:2]};
	endfunction

	////////////////////////////////////////////////////////////
	// Menu info code and request

	always_ff @(posedge clk_sys) begin
		if (synth_mode == `SYNTH_MODE_FONT)
			info_code <= 4'd1 + info_code_t'(synth_sf[2:0]);
		else if (synth_mode == `SYNTH_MODE_ROM && synth_rom < 8'd3)
			info_code <= 4'd9 + info_code_t'(synth_rom[1:0]);
		else
			info_code <= 4'd12;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			old_newmode <= 1'b0;
			info_req    <= 1'b0;
			old_update  <= 1'b0;
			lcd_on      <= 1'b0;
			hold_cnt    <= '0;
		end else begin
			old_newmode <= synth_newmode;
			info_req    <= (old_newmode ^ synth_newmode) && (info_mode == info_menu);
			old_update  <= lcd_update;
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			// LCD state per display mode
			case (info_mode)
				info_lcd_on:   lcd_on <= 1'b1;
				info_lcd_auto: begin
					if (hold_cnt == '0)
						lcd_on <= 1'b0;
					// Each LCD refresh restarts the hold window
					if (old_update ^ lcd_update) begin
						lcd_on   <= 1'b1;
						hold_cnt <= HOLD_W'(lcd_hold - 1);
					end
				end
				default:       lcd_on <= 1'b0;
			endcase
		end
	end

	// Pixel overlay is combinational on the video path
	assign overlay = lcd_on & lcd_en;

	assign video_out.red   = overlay ? blend(video_in.red, lcd_pix) : video_in.red;
	assign video_out.green = overlay ? blend(video_in.green, lcd_pix) : video_in.green;
	assign video_out.blue  = overlay ? blend(video_in.blue, lcd_pix) : video_in.blue;

endmodule

`default_nettype wire

// ==== src/audio_mix.sv ====
// Audio mixer, sums core and synth audio and runs an optional two-curve compressor per channel
`default_nettype none
`timescale 1ns/1ps

`include "core_glue_params.svh"

module audio_mix
	import core_pkg::*;
(
	input  logic    clk_sys,
	input  logic    rst_n,
	input  stereo_t core_audio,
	input  stereo_t synth_audio,
	input  logic    synth_mute,
	input  logic    cmp_en,
	input  logic    cmp_curve,
	output stereo_t audio_out
);

	stereo_t synth_gated;
	stereo_t sum_q;
	logic    cmp_en_q;
	logic    cmp_curve_q;

	// Linear below the knee, flattened slope above it
	function automatic logic [15:0] knee_curve(input logic [15:0] mag, input logic [15:0] knee,
			input logic [15:0] gain, input logic [15:0] fall, input logic [15:0] base);
		if (mag < knee)
			return mag * gain;
		return ((mag - knee) / fall) + base;
	endfunction

	function automatic sample_t compress(input sample_t smp, input logic curve_sel);
		logic [15:0] mag;
		logic [15:0] shaped;
		mag = smp[15] ? 16'(-smp) : 16'(smp);
		if (curve_sel)
			shaped = knee_curve(mag, `CMP2_KNEE, `CMP2_GAIN, `CMP2_FALL, `CMP2_BASE);
		else
			shaped = knee_curve(mag, `CMP1_KNEE, `CMP1_GAIN, `CMP1_FALL, `CMP1_BASE);
		// Sign goes back on after shaping
		return smp[15] ? sample_t'(-shaped) : sample_t'(shaped);
	endfunction

	// Muted synth counts as silence
	assign synth_gated = synth_mute ? '0 : synth_audio;

	////////////////////////////////////////////////////////////
	// Stage 1 wrapping sum, stage 2 compressor

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmp_en_q    <= 1'b0;
			cmp_curve_q <= 1'b0;
		end else begin
			// Controls travel with their sample
			cmp_en_q    <= cmp_en;
			cmp_curve_q <= cmp_curve;
		end
	end

	always_ff @(posedge clk_sys) begin
		sum_q.left  <= core_audio.left + synth_gated.left;
		sum_q.right <= core_audio.right + synth_gated.right;
		audio_out.left  <= cmp_en_q ? compress(sum_q.left, cmp_curve_q) : sum_q.left;
		audio_out.right <= cmp_en_q ? compress(sum_q.right, cmp_curve_q) : sum_q.right;
	end

endmodule

`default_nettype wire

// ==== src/ce_gen.sv ====
// Clock enable generator, divides clk_sys into CPU phase strobes and sound chip strobes
`default_nettype none
`timescale 1ns/1ps

`include "core_glue_params.svh"

module ce_gen
	import core_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	input  logic snd_slow,
	output ce_t  ce
);

	// One counter width covers the longest ratio
	localparam int CNT_W = $clog2(`OPN_DIV_SLOW);

	typedef logic [CNT_W-1:0] div_cnt_t;

	localparam div_cnt_t SYS_LAST  = div_cnt_t'(`SYS_CE_DIV - 1);
	// Negative phase sits half a CPU period before the positive one
	localparam div_cnt_t SYS_MID   = div_cnt_t'(`SYS_CE_DIV / 2 - 1);
	localparam div_cnt_t SNDF_LAST = div_cnt_t'(`SND_DIV_FAST - 1);
	localparam div_cnt_t OPNF_LAST = div_cnt_t'(`OPN_DIV_FAST - 1);
	localparam div_cnt_t OPNS_LAST = div_cnt_t'(`OPN_DIV_SLOW - 1);

	div_cnt_t div_sys;
	div_cnt_t div_snd;
	div_cnt_t div_opn_f;
	div_cnt_t div_opn_s;

	function automatic div_cnt_t next_cnt(input div_cnt_t cnt, input div_cnt_t last);
		return (cnt == last) ? '0 : cnt + 1'b1;
	endfunction

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_sys   <= '0;
			div_snd   <= '0;
			div_opn_f <= '0;
			div_opn_s <= '0;
			ce        <= '0;
		end else begin
			div_sys   <= next_cnt(div_sys, SYS_LAST);
			div_snd   <= next_cnt(div_snd, SNDF_LAST);
			div_opn_f <= next_cnt(div_opn_f, OPNF_LAST);
			div_opn_s <= next_cnt(div_opn_s, OPNS_LAST);

			// Terminal counts become one-cycle strobes
			ce.sys_cep   <= (div_sys == SYS_LAST);
			ce.sys_cen   <= (div_sys == SYS_MID);
			ce.opn_ce[0] <= (div_opn_f == OPNF_LAST);
			ce.opn_ce[1] <= (div_opn_s == OPNS_LAST);
			// Slow sound mode shares the OPN fast counter
			ce.snd_ce    <= snd_slow ? (div_opn_f == OPNF_LAST) : (div_snd == SNDF_LAST);
		end
	end

endmodule

`default_nettype wire

// ==== src/loader_bridge.sv ====
// ROM loader bridge, turns host download strobes into write requests held until the core acks
`default_nettype none
`timescale 1ns/1ps

module loader_bridge
	import core_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      download,
	input  logic      ioctl_wr,
	input  logic      ldr_ack,
	input  ldr_addr_t ioctl_addr,
	input  ldr_data_t ioctl_dout,
	output logic      ldr_wr,
	output logic      ldr_aen,
	output logic      ldr_done,
	output ldr_addr_t ldr_addr,
	output ldr_data_t ldr_data
);

	logic old_ack;
	logic old_dl;
	logic ack_rise;
	logic dl_fall;
	logic wr_accept;

	assign ack_rise  = ~old_ack & ldr_ack;
	assign dl_fall   = old_dl & ~download;
	// Writes after the load has finished are dropped
	assign wr_accept = ioctl_wr & ~ldr_done;

	// Address enable only while the first download is running
	assign ldr_aen = download & ~ldr_done;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			old_ack  <= 1'b0;
			old_dl   <= 1'b0;
			ldr_wr   <= 1'b0;
			ldr_done <= 1'b0;
		end else begin
			old_ack <= ldr_ack;
			old_dl  <= download;
			// New host byte wins over a release in the same cycle
			if (wr_accept)
				ldr_wr <= 1'b1;
			else if (ack_rise && ldr_wr)
				ldr_wr <= 1'b0;
			if (dl_fall)
				ldr_done <= 1'b1;
		end
	end

	// Payload latch
	always_ff @(posedge clk_sys) begin
		if (wr_accept) begin
			ldr_addr <= ioctl_addr;
			ldr_data <= ioctl_dout;
		end
	end

endmodule

`default_nettype wire

// ==== src/reset_seq.sv ====
// Core reset sequencer, holds the core in reset until a download and a host reset pulse release it
`default_nettype none
`timescale 1ns/1ps

module reset_seq
	import core_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n,
	input  logic user_btn,
	input  logic host_reset,
	input  logic download,
	output logic core_rst_n
);

	rst_flags_t flags;
	logic       init_next;
	logic       run_next;

	// Host reset bit must fall once before the core may run
	assign init_next = flags.init_done | (flags.old_rst & ~host_reset);
	// First download start marks a loaded system
	assign run_next  = flags.run | (~flags.old_dl & download);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			flags      <= '0;
			core_rst_n <= 1'b0;
		end else begin
			flags.old_rst   <= host_reset;
			flags.old_dl    <= download;
			flags.init_done <= init_next;
			flags.run       <= run_next;
			// Button and host reset win over the release flags
			core_rst_n <= init_next & run_next & ~user_btn & ~host_reset;
		end
	end

endmodule

`default_nettype wire

// ==== src/core_pkg.sv ====
// Shared types of the core glue logic, imported by every block that moves samples, pixels or flags
`default_nettype none

`include "core_glue_params.svh"

package core_pkg;

	// Plain vectors with a meaning
	typedef logic signed [`SAMPLE_W-1:0]    sample_t;
	typedef logic [`CHAN_W-1:0]             chan_t;
	typedef logic [`STATUS_W-1:0]           status_t;
	typedef logic [`INFO_CODE_W-1:0]        info_code_t;
	typedef logic [`LDR_ADDR_W-1:0]         ldr_addr_t;
	typedef logic [`LDR_DATA_W-1:0]         ldr_data_t;

	// One stereo sample pair, left in the upper half
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef struct packed {
		chan_t red;
		chan_t green;
		chan_t blue;
	} rgb_t;

	// Clock enables handed to the core
	typedef struct packed {
		logic       sys_cep;
		logic       sys_cen;
		logic       snd_ce;
		logic [1:0] opn_ce;
	} ce_t;

	// Reset sequencer history and release flags
	typedef struct packed {
		logic init_done;
		logic run;
		logic old_rst;
		logic old_dl;
	} rst_flags_t;

	// Synth info display selection from the host menu
	typedef enum logic [1:0] {
		info_off      = 2'd0,
		info_menu     = 2'd1,
		info_lcd_on   = 2'd2,
		info_lcd_auto = 2'd3
	} info_mode_t;

endpackage

`default_nettype wire

// ==== include/core_glue_params.svh ====
// Width, divider, compressor and status-bit macros for the core glue, included where needed
`ifndef CORE_GLUE_PARAMS_SVH
`define CORE_GLUE_PARAMS_SVH

// Bus and sample widths
`define SAMPLE_W         16
`define CHAN_W           8
`define STATUS_W         64
`define INFO_CODE_W      4
`define LDR_ADDR_W       20
`define LDR_DATA_W       8

// Clock enable divider ratios in clk_sys cycles
`define SYS_CE_DIV       4
`define SND_DIV_FAST     5
`define SND_DIV_SLOW     10
`define OPN_DIV_FAST     `SND_DIV_SLOW
`define OPN_DIV_SLOW     20

// Compressor curve 1, gentle
`define CMP1_KNEE        14044
`define CMP1_GAIN        2
`define CMP1_FALL        4
`define CMP1_BASE        28088
// Compressor curve 2, hard
`define CMP2_KNEE        7400
`define CMP2_GAIN        4
`define CMP2_FALL        8
`define CMP2_BASE        29600

// Synth mode bytes reported by the synth
`define SYNTH_MODE_FONT  8'hA2
`define SYNTH_MODE_ROM   8'hA1

// LCD overlay hold in auto mode, about two seconds
`define LCD_HOLD_DEFAULT 180000000

// Host status word bit map
`define ST_RESET         0
`define ST_CMP_EN        2
`define ST_SYNTH_DIS     18
`define ST_CMP_CURVE     21
`define ST_SND_MODE      34
`define ST_INFO_LO       41

`endif
